//--- src/hpp_pkg.sv
// shared widths, line types, FSM states and AXI user codes; compile before every RTL file
package hpp_pkg;

    // line and page geometry
    localparam int LINE_BYTES     = 64;
    localparam int LINE_W         = LINE_BYTES * 8;
    localparam int LINES_PER_PAGE = 64;        // 4 KiB page
    localparam int OFFSET_W       = 6;

    // AXI widths
    localparam int ADDR_W = 64;
    localparam int ID_W   = 12;

    typedef logic [OFFSET_W-1:0] line_offset_t;   // line index within the page
    typedef logic [LINE_W-1:0]   line_data_t;

    // one FIFO slot, offset sits above the line data
    typedef struct packed {
        line_offset_t offset;
        line_data_t   data;
    } fifo_entry_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_COPY,     // reads still being issued
        CTRL_DRAIN,    // waiting on writes and responses
        CTRL_DONE
    } ctrl_state_t;

    // writer states name the halves that are still pending
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BOTH,
        WR_ADDR_ONLY,
        WR_DATA_ONLY
    } wr_state_t;

    // user field codes
    localparam logic [5:0] ARUSER_OWNED   = 6'b10_0010;   // cacheable owned read
    localparam logic [5:0] AWUSER_DEFAULT = 6'b00_0000;

endpackage

//--- src/line_fifo.sv
// line buffer between reader and writer; first-word-fall-through head, entries carry their offset
`timescale 1ns/10ps

module line_fifo
    import hpp_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        axi4_mm_clk,
    input  logic        reset,
    input  logic        push,
    input  fifo_entry_t push_entry,
    input  logic        pop,
    output fifo_entry_t head,
    output logic        full,
    output logic        empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    fifo_entry_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic             do_pop;

    assign head   = mem[rd_ptr];   // valid whenever not empty
    assign empty  = (fill == '0);
    assign full   = (fill == (PTR_W+1)'(FIFO_DEPTH));
    assign do_pop = pop && !empty;

    always_ff @(posedge axi4_mm_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap, depth is a power of two
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !do_pop) begin
                fill <= fill + 1'b1;
            end else if (!push && do_pop) begin
                fill <= fill - 1'b1;
            end
        end
    end

endmodule

//--- src/req_tracker.sv
// counts reads and writes in flight and keeps the migration-done counter
`timescale 1ns/10ps

module req_tracker #(
    parameter int CNT_W = 8
) (
    input  logic        axi4_mm_clk,
    input  logic        reset,
    input  logic        ar_fire,
    input  logic        r_fire,
    input  logic        w_fire,
    input  logic        b_fire,
    input  logic        done_pulse,
    output logic        idle_out,
    output logic [63:0] mig_done_cnt
);

    logic [CNT_W-1:0] rd_inflight;   // ARs without their R beat
    logic [CNT_W-1:0] wr_inflight;   // W beats without their B response

    assign idle_out = (rd_inflight == '0) && (wr_inflight == '0);

    always_ff @(posedge axi4_mm_clk) begin
        if (reset) begin
            rd_inflight <= '0;
            wr_inflight <= '0;
        end else begin
            // request and response in the same cycle cancel out
            if (ar_fire && !r_fire) begin
                rd_inflight <= rd_inflight + 1'b1;
            end else if (!ar_fire && r_fire) begin
                rd_inflight <= rd_inflight - 1'b1;
            end

            if (w_fire && !b_fire) begin
                wr_inflight <= wr_inflight + 1'b1;
            end else if (!w_fire && b_fire) begin
                wr_inflight <= wr_inflight - 1'b1;
            end
        end
    end

    // one step per finished command, zero-address ones included
    always_ff @(posedge axi4_mm_clk) begin
        if (reset) begin
            mig_done_cnt <= '0;
        end else if (done_pulse) begin
            mig_done_cnt <= mig_done_cnt + 1'b1;
        end
    end

endmodule

//--- src/migration_ctrl.sv
// command FSM of the pusher; accepts a migration, starts the copy and signals completion
`timescale 1ns/10ps

module migration_ctrl
    import hpp_pkg::*;
(
    input  logic              axi4_mm_clk,
    input  logic              reset,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  logic [ADDR_W-1:0] src_addr,
    input  logic [ADDR_W-1:0] dst_addr,
    input  logic              reads_issued_all,
    input  logic              writes_sent_all,
    input  logic              idle_out,
    output logic              start,
    output logic [ADDR_W-1:0] src_base,
    output logic [ADDR_W-1:0] dst_base,
    output logic              done_pulse
);

    ctrl_state_t state, state_next;
    logic        accept;
    logic        zero_cmd;

    assign cmd_ready  = (state == CTRL_IDLE);
    assign accept     = cmd_valid && cmd_ready;
    assign zero_cmd   = (src_addr == '0) || (dst_addr == '0);   // pusher control, no copy
    assign done_pulse = (state == CTRL_DONE);

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: begin
                if (accept) begin
                    state_next = zero_cmd ? CTRL_DONE : CTRL_COPY;
                end
            end
            CTRL_COPY: begin
                // flag from the last page is still up while start is high
                if (!start && reads_issued_all) begin
                    state_next = CTRL_DRAIN;
                end
            end
            CTRL_DRAIN: begin
                if (writes_sent_all && idle_out) begin
                    state_next = CTRL_DONE;
                end
            end
            default: state_next = CTRL_IDLE;   // done lasts one cycle
        endcase
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (reset) begin
            state <= CTRL_IDLE;
            start <= 1'b0;
        end else begin
            state <= state_next;
            start <= accept && !zero_cmd;   // one cycle, reader and writer rearm on it
        end
    end

    // page bases, held for the whole migration
    always_ff @(posedge axi4_mm_clk) begin
        if (accept) begin
            src_base <= src_addr;
            dst_base <= dst_addr;
        end
    end

endmodule

//--- src/page_reader.sv
// AXI read side; walks the 64 lines of the source page and pushes each returned line to the FIFO
`timescale 1ns/10ps

module page_reader
    import hpp_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int PUSHER_POS = 0
) (
    input  logic              axi4_mm_clk,
    input  logic              reset,
    input  logic              start,
    input  logic [ADDR_W-1:0] src_base,
    input  logic              fifo_full,
    output logic              push,
    output fifo_entry_t       push_entry,
    output logic [ID_W-1:0]   arid,
    output logic [ADDR_W-1:0] araddr,
    output logic [5:0]        aruser,
    output logic              arvalid,
    input  logic              arready,
    input  logic [ID_W-1:0]   rid,
    input  line_data_t        rdata,
    input  logic              rvalid,
    output logic              rready,
    output logic              reads_issued_all
);

    localparam int CRED_W = $clog2(FIFO_DEPTH) + 1;
    localparam logic [ID_W-OFFSET_W-1:0] ID_HI = (ID_W-OFFSET_W)'(PUSHER_POS);

    line_offset_t      ar_offset;
    logic              rd_active;   // page not fully requested yet
    logic [CRED_W-1:0] rd_credit;   // reads out, capped at the FIFO depth
    logic              ar_fire;

    // credit only drops without an AR, so a raised arvalid stays up
    assign arvalid = rd_active && (rd_credit < CRED_W'(FIFO_DEPTH));
    assign ar_fire = arvalid && arready;
    assign araddr  = src_base + (ADDR_W'(ar_offset) << $clog2(LINE_BYTES));
    assign arid    = {ID_HI, ar_offset};
    assign aruser  = ARUSER_OWNED;

    // R is back-pressured by the FIFO, returns may come in any order
    assign rready            = !fifo_full;
    assign push              = rvalid && rready;
    assign push_entry.offset = rid[OFFSET_W-1:0];
    assign push_entry.data   = rdata;

    always_ff @(posedge axi4_mm_clk) begin
        if (reset) begin
            ar_offset        <= '0;
            rd_active        <= 1'b0;
            rd_credit        <= '0;
            reads_issued_all <= 1'b0;
        end else begin
            if (start) begin
                ar_offset        <= '0;
                rd_active        <= 1'b1;
                reads_issued_all <= 1'b0;
            end else if (ar_fire) begin
                ar_offset <= ar_offset + 1'b1;
                if (ar_offset == line_offset_t'(LINES_PER_PAGE - 1)) begin
                    rd_active        <= 1'b0;
                    reads_issued_all <= 1'b1;   // sticky until next start
                end
            end

            if (ar_fire && !push) begin
                rd_credit <= rd_credit + 1'b1;
            end else if (!ar_fire && push) begin
                rd_credit <= rd_credit - 1'b1;
            end
        end
    end

endmodule

//--- src/page_writer.sv
// AXI write side; drains the FIFO into the destination page, AW and W complete independently
`timescale 1ns/10ps

module page_writer
    import hpp_pkg::*;
#(
    parameter int PUSHER_POS = 0
) (
    input  logic                  axi4_mm_clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [ADDR_W-1:0]     dst_base,
    input  logic                  empty,
    input  fifo_entry_t           head,
    output logic                  pop,
    output logic [ID_W-1:0]       awid,
    output logic [ADDR_W-1:0]     awaddr,
    output logic [5:0]            awuser,
    output logic                  awvalid,
    input  logic                  awready,
    output line_data_t            wdata,
    output logic [LINE_BYTES-1:0] wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    output logic                  bready,
    output logic                  writes_sent_all
);

    localparam logic [ID_W-OFFSET_W-1:0] ID_HI = (ID_W-OFFSET_W)'(PUSHER_POS);

    wr_state_t    state, state_next;
    line_offset_t w_count;   // accepted W beats of this page
    logic         aw_fire;
    logic         w_fire;

    assign awvalid = (state == WR_BOTH) || (state == WR_ADDR_ONLY);
    assign wvalid  = (state == WR_BOTH) || (state == WR_DATA_ONLY);
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // payload straight from the FIFO head, which holds until the pop
    assign awaddr = dst_base + (ADDR_W'(head.offset) << $clog2(LINE_BYTES));
    assign awid   = {ID_HI, head.offset};
    assign awuser = AWUSER_DEFAULT;
    assign wdata  = head.data;
    assign wstrb  = '1;     // full line every beat
    assign wlast  = 1'b1;   // single-beat bursts
    assign bready = 1'b1;

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        case (state)
            WR_IDLE: if (!empty) state_next = WR_BOTH;
            WR_BOTH: begin
                if (aw_fire && w_fire) begin
                    pop        = 1'b1;
                    state_next = WR_IDLE;
                end else if (aw_fire) begin
                    state_next = WR_DATA_ONLY;
                end else if (w_fire) begin
                    state_next = WR_ADDR_ONLY;
                end
            end
            WR_ADDR_ONLY: begin
                pop = aw_fire;
                if (aw_fire) state_next = WR_IDLE;
            end
            default: begin   // data half still pending
                pop = w_fire;
                if (w_fire) state_next = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (reset) begin
            state           <= WR_IDLE;
            w_count         <= '0;
            writes_sent_all <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                w_count         <= '0;
                writes_sent_all <= 1'b0;
            end else if (w_fire) begin
                w_count <= w_count + 1'b1;
                if (w_count == line_offset_t'(LINES_PER_PAGE - 1)) writes_sent_all <= 1'b1;
            end
        end
    end

endmodule

//--- src/hot_page_pusher.sv
// top of the hot page pusher; one command in, page copy over AXI4 out, done counter as status
`timescale 1ns/10ps

module hot_page_pusher
    import hpp_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int PUSHER_POS = 0,   // 0 to 15, upper ID bits
    parameter int CNT_W      = 8
) (
    input  logic                  axi4_mm_clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic [ADDR_W-1:0]     src_addr,
    input  logic [ADDR_W-1:0]     dst_addr,
    output logic [ID_W-1:0]       arid,
    output logic [ADDR_W-1:0]     araddr,
    output logic [5:0]            aruser,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [ID_W-1:0]       rid,
    input  logic [LINE_W-1:0]     rdata,
    input  logic                  rvalid,
    output logic                  rready,
    output logic [ID_W-1:0]       awid,
    output logic [ADDR_W-1:0]     awaddr,
    output logic [5:0]            awuser,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [LINE_W-1:0]     wdata,
    output logic [LINE_BYTES-1:0] wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic [ID_W-1:0]       bid,   // IDs come back unchecked
    input  logic                  bvalid,
    output logic                  bready,
    output logic [63:0]           mig_done_cnt
);

    logic              start, done_pulse, idle_out;
    logic [ADDR_W-1:0] src_base, dst_base;
    logic              reads_issued_all, writes_sent_all;
    logic              push, pop, fifo_full, fifo_empty;
    fifo_entry_t       push_entry, fifo_head;

    migration_ctrl u_ctrl (
        .axi4_mm_clk(axi4_mm_clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .src_addr(src_addr), .dst_addr(dst_addr),
        .reads_issued_all(reads_issued_all), .writes_sent_all(writes_sent_all),
        .idle_out(idle_out), .start(start),
        .src_base(src_base), .dst_base(dst_base), .done_pulse(done_pulse)
    );

    req_tracker #(.CNT_W(CNT_W)) u_tracker (
        .axi4_mm_clk(axi4_mm_clk), .reset(reset),
        .ar_fire(arvalid && arready), .r_fire(rvalid && rready),
        .w_fire(wvalid && wready), .b_fire(bvalid && bready),
        .done_pulse(done_pulse), .idle_out(idle_out), .mig_done_cnt(mig_done_cnt)
    );

    page_reader #(.FIFO_DEPTH(FIFO_DEPTH), .PUSHER_POS(PUSHER_POS)) u_reader (
        .axi4_mm_clk(axi4_mm_clk), .reset(reset),
        .start(start), .src_base(src_base), .fifo_full(fifo_full),
        .push(push), .push_entry(push_entry),
        .arid(arid), .araddr(araddr), .aruser(aruser), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .reads_issued_all(reads_issued_all)
    );

    line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .axi4_mm_clk(axi4_mm_clk), .reset(reset),
        .push(push), .push_entry(push_entry), .pop(pop),
        .head(fifo_head), .full(fifo_full), .empty(fifo_empty)
    );

    page_writer #(.PUSHER_POS(PUSHER_POS)) u_writer (
        .axi4_mm_clk(axi4_mm_clk), .reset(reset),
        .start(start), .dst_base(dst_base),
        .empty(fifo_empty), .head(fifo_head), .pop(pop),
        .awid(awid), .awaddr(awaddr), .awuser(awuser), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bready(bready), .writes_sent_all(writes_sent_all)
    );

endmodule

//--- tests/axi_mem_model.sv
// AXI4 slave model for the testbench; out-of-order source reads, recorded destination writes
`timescale 1ns/10ps

module axi_mem_model
    import hpp_pkg::*;
#(
    parameter int          READY_PCT = 70,   // chance in percent that a ready or a response shows up
    parameter int unsigned SEED      = 1     // seed of the stall and return-order draws
) (
    input  logic              axi4_mm_clk,
    input  logic              reset,
    input  logic [ID_W-1:0]   arid,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [ID_W-1:0]   rid,
    output logic [LINE_W-1:0] rdata,
    output logic              rvalid,
    input  logic              rready,
    input  logic [ID_W-1:0]   awid,
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [LINE_W-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic [ID_W-1:0]   bid,
    output logic              bvalid,
    input  logic              bready
);

    logic [LINE_W-1:0] src_mem [logic [ADDR_W-1:0]];   // filled by the testbench
    logic [LINE_W-1:0] dst_mem [logic [ADDR_W-1:0]];
    int unsigned       write_count [logic [ADDR_W-1:0]];

    logic [ID_W-1:0]   rd_id_q [$];     // reads waiting for their R beat
    logic [ADDR_W-1:0] rd_addr_q [$];
    logic [ID_W-1:0]   aw_id_q [$];
    logic [ADDR_W-1:0] aw_addr_q [$];
    logic [LINE_W-1:0] w_data_q [$];
    logic [ID_W-1:0]   b_id_q [$];

    function automatic logic coin();
        return ($urandom % 100) < READY_PCT;
    endfunction

    initial begin
        logic [ADDR_W-1:0] addr;
        int unsigned       pick;
        logic              r_done;
        logic              b_done;
        void'($urandom(SEED));
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        bid     = '0;
        forever begin
            @(posedge axi4_mm_clk);
            // handshakes of the cycle that just ended
            if (!reset && arvalid && arready) begin
                rd_id_q.push_back(arid);
                rd_addr_q.push_back(araddr);
            end
            if (!reset && awvalid && awready) begin
                aw_id_q.push_back(awid);
                aw_addr_q.push_back(awaddr);
            end
            if (!reset && wvalid && wready) w_data_q.push_back(wdata);
            r_done = rvalid && rready;
            b_done = bvalid && bready;
            while (aw_addr_q.size() > 0 && w_data_q.size() > 0) begin
                addr = aw_addr_q.pop_front();
                dst_mem[addr] = w_data_q.pop_front();
                write_count[addr] = write_count[addr] + 1;
                b_id_q.push_back(aw_id_q.pop_front());
            end
            #2;
            arready = coin();
            awready = coin();
            wready  = coin();
            if (r_done || !rvalid) begin
                rvalid = 1'b0;
                if (rd_id_q.size() > 0 && coin()) begin
                    pick  = $urandom % rd_id_q.size();   // any pending read may come back first
                    rid   = rd_id_q[pick];
                    rdata = src_mem[rd_addr_q[pick]];
                    rd_id_q.delete(pick);
                    rd_addr_q.delete(pick);
                    rvalid = 1'b1;
                end
            end
            if (b_done || !bvalid) begin
                bvalid = 1'b0;
                if (b_id_q.size() > 0 && coin()) begin
                    bid    = b_id_q.pop_front();
                    bvalid = 1'b1;
                end
            end
        end
    end

endmodule

//--- tests/tb_hot_page_pusher.sv
// testbench for the hot page pusher; copy and zero-address commands against the AXI memory model
`timescale 1ns/10ps

module tb_hot_page_pusher
    import hpp_pkg::*;
();

    localparam int PUSHER_POS = 5;
    localparam int NUM_CMDS   = 4;
    localparam int TIMEOUT_NS = NUM_CMDS * LINES_PER_PAGE * 40 * 20;

    logic axi4_mm_clk, reset, cmd_valid, cmd_ready;
    logic [ADDR_W-1:0] src_addr, dst_addr, araddr, awaddr;
    logic [ID_W-1:0] arid, rid, awid, bid;
    logic [5:0] aruser, awuser;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    logic [LINE_W-1:0] rdata, wdata;
    logic [LINE_BYTES-1:0] wstrb;
    logic wlast;
    logic [63:0] mig_done_cnt;

    // written by the command tasks only
    logic [63:0] cur_src, cur_dst, done_base;
    int unsigned ar_base, aw_base, b_base, expect_b;
    logic busy;
    // written by the bus monitor only
    int unsigned ar_count = 0, aw_count = 0, b_count = 0;
    logic [63:0] last_done = '0;

    hot_page_pusher #(.PUSHER_POS(PUSHER_POS)) dut (.*);

    axi_mem_model #(.SEED(97377)) mem (
        .axi4_mm_clk(axi4_mm_clk), .reset(reset),
        .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bvalid(bvalid), .bready(bready)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run stopped at the first failed check");
    endtask

    task automatic fail_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        stop_run($sformatf("error at %0t: %s expected %0h actual %0h",
                           $time, name, expected, actual));
    endtask

    task automatic fail_line(input string name, input logic [LINE_W-1:0] expected,
                             input logic [LINE_W-1:0] actual);
        stop_run($sformatf("error at %0t: %s expected %0h actual %0h",
                           $time, name, expected, actual));
    endtask

    // every 64-bit word mixes the full line address
    function automatic logic [LINE_W-1:0] line_pattern(input logic [63:0] addr);
        logic [LINE_W-1:0] line;
        int i;
        for (i = 0; i < LINE_W / 64; i++) begin
            line[i*64 +: 64] = addr ^ (64'h9e37_79b9_7f4a_7c15 * 64'(i + 1));
        end
        return line;
    endfunction

    initial begin
        axi4_mm_clk = 1'b0;
        forever #20 axi4_mm_clk = ~axi4_mm_clk;
    end

    initial begin
        #(TIMEOUT_NS);
        stop_run("timeout: the pusher did not finish its commands in time");
    end

    // valid must hold with a stable payload until ready
    assert property (@(posedge axi4_mm_clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
        else stop_run("arvalid dropped or its payload changed before arready");
    assert property (@(posedge axi4_mm_clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
        else stop_run("awvalid dropped or its payload changed before awready");
    assert property (@(posedge axi4_mm_clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else stop_run("wvalid dropped or its data changed before wready");

    always @(negedge axi4_mm_clk) begin
        logic [63:0] exp_addr;
        logic [11:0] exp_id;
        if (!reset) begin
            if (arvalid && arready) begin
                assert (ar_count - ar_base < 64) else stop_run("more than 64 reads in one command");
                exp_addr = cur_src + (64'(ar_count - ar_base) << 6);
                exp_id   = {6'(PUSHER_POS), 6'(ar_count - ar_base)};
                assert (araddr == exp_addr) else fail_value("araddr", exp_addr, araddr);
                assert (arid == exp_id) else fail_value("arid", 64'(exp_id), 64'(arid));
                assert (aruser == ARUSER_OWNED)
                    else fail_value("aruser", 64'(ARUSER_OWNED), 64'(aruser));
                ar_count++;
            end
            if (awvalid && awready) begin
                exp_addr = cur_dst + (64'(awid[5:0]) << 6);
                assert (awaddr == exp_addr) else fail_value("awaddr", exp_addr, awaddr);
                assert (awid[11:6] == 6'(PUSHER_POS))
                    else fail_value("awid upper bits", 64'(PUSHER_POS), 64'(awid[11:6]));
                assert (awuser == AWUSER_DEFAULT)
                    else fail_value("awuser", 64'(AWUSER_DEFAULT), 64'(awuser));
                aw_count++;
            end
            if (wvalid && wready) begin   // full line in a single beat
                assert (wstrb == '1) else fail_value("wstrb", '1, 64'(wstrb));
                assert (wlast == 1'b1) else fail_value("wlast", 64'd1, 64'(wlast));
            end
            if (bvalid && bready) b_count++;
            if (mig_done_cnt != last_done) begin   // done count moves by one, after every B
                assert (mig_done_cnt == last_done + 64'd1)
                    else fail_value("mig_done_cnt", last_done + 64'd1, mig_done_cnt);
                assert (b_count - b_base == expect_b)
                    else fail_value("b responses before done", 64'(expect_b), 64'(b_count - b_base));
                last_done = mig_done_cnt;
            end
            assert (!(busy && cmd_ready && mig_done_cnt == done_base))
                else stop_run("cmd_ready went high while a migration was running");
        end
    end

    task automatic fill_source(input logic [63:0] base);
        int off;
        logic [63:0] a;
        for (off = 0; off < LINES_PER_PAGE; off++) begin
            a = base + (64'(off) << 6);
            mem.src_mem[a] = line_pattern(a);
        end
    endtask

    task automatic send_command(input logic [63:0] src, input logic [63:0] dst,
                                input int unsigned lines);
        cur_src   = src;
        cur_dst   = dst;
        expect_b  = lines;
        ar_base   = ar_count;
        aw_base   = aw_count;
        b_base    = b_count;
        done_base = mig_done_cnt;
        cmd_valid = 1'b1;
        src_addr  = src;
        dst_addr  = dst;
        do @(posedge axi4_mm_clk); while (!cmd_ready);
        #2;
        busy      = 1'b1;
        cmd_valid = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
    endtask

    task automatic wait_done(output int unsigned cycles);
        cycles = 0;
        while (mig_done_cnt == done_base) begin
            @(negedge axi4_mm_clk);
            cycles++;
        end
        busy = 1'b0;
    endtask

    task automatic run_copy(input logic [63:0] src, input logic [63:0] dst);
        int unsigned cycles;
        int off;
        logic [63:0] d;
        logic [LINE_W-1:0] expected;
        fill_source(src);
        send_command(src, dst, LINES_PER_PAGE);
        wait_done(cycles);
        assert (ar_count - ar_base == 64)
            else fail_value("read count", 64'd64, 64'(ar_count - ar_base));
        assert (aw_count - aw_base == 64)
            else fail_value("write count", 64'd64, 64'(aw_count - aw_base));
        for (off = 0; off < LINES_PER_PAGE; off++) begin
            d        = dst + (64'(off) << 6);
            expected = line_pattern(src + (64'(off) << 6));
            assert (mem.dst_mem[d] == expected)
                else fail_line($sformatf("dst line %0d", off), expected, mem.dst_mem[d]);
            assert (mem.write_count[d] == 1)   // each line lands exactly once
                else fail_value($sformatf("writes to line %0d", off), 64'd1, 64'(mem.write_count[d]));
        end
        @(posedge axi4_mm_clk);
        #2;
    endtask

    task automatic run_zero(input logic [63:0] src, input logic [63:0] dst);
        int unsigned cycles;
        send_command(src, dst, 0);
        wait_done(cycles);
        assert (cycles == 2) else fail_value("zero command done latency", 64'd2, 64'(cycles));
        assert (ar_count == ar_base && aw_count == aw_base)
            else stop_run("AXI traffic seen on a zero-address command");
        @(posedge axi4_mm_clk);
        #2;
    endtask

    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        busy      = 1'b0;
        cur_src   = '0;
        cur_dst   = '0;
        done_base = '0;
        ar_base   = 0;
        aw_base   = 0;
        b_base    = 0;
        expect_b  = 0;
        repeat (8) @(posedge axi4_mm_clk);
        #2;
        reset = 1'b0;
        @(negedge axi4_mm_clk);
        assert (cmd_ready == 1'b1) else fail_value("cmd_ready", 64'd1, 64'(cmd_ready));
        assert (arvalid == 1'b0) else fail_value("arvalid", 64'd0, 64'(arvalid));
        assert (awvalid == 1'b0) else fail_value("awvalid", 64'd0, 64'(awvalid));
        assert (wvalid == 1'b0) else fail_value("wvalid", 64'd0, 64'(wvalid));
        assert (mig_done_cnt == 64'd0) else fail_value("mig_done_cnt", 64'd0, mig_done_cnt);
        @(posedge axi4_mm_clk);
        #2;
        run_copy(64'h0000_0001_0000_0000, 64'h0000_0002_0004_0000);
        run_zero(64'h0, 64'h0000_0003_0000_0000);
        run_zero(64'h0000_0003_1000_0000, 64'h0);
        run_copy(64'h0000_0004_0000_3000, 64'h0000_0005_0001_7000);
        assert (mig_done_cnt == 64'(NUM_CMDS))
            else fail_value("mig_done_cnt", 64'(NUM_CMDS), mig_done_cnt);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- src.f
src/hpp_pkg.sv
src/line_fifo.sv
src/req_tracker.sv
src/migration_ctrl.sv
src/page_reader.sv
src/page_writer.sv
src/hot_page_pusher.sv
tests/axi_mem_model.sv
tests/tb_hot_page_pusher.sv

//--- Makefile
# Verilator build and run of the hot page pusher testbench

VERILATOR ?= verilator
TOP       ?= tb_hot_page_pusher
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
